// File: build.f
hw/axi_meta_pkg.sv
hw/noc_meta_pkg.sv
hw/meta_fifo_if.sv
hw/meta_fifo.sv
hw/atop_slot_table.sv
hw/meta_buffer.sv
hw/meta_buffer_top.sv
sim/tb_meta_buffer.sv

// File: Makefile
# Verilator build, lint and run of the meta buffer testbench

TOP := tb_meta_buffer

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -qF '** PASS **'

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: sim/tb_meta_buffer.sv
// Testbench of the meta buffer, driving AXI-style requests and responses and checking by assertions
`timescale 1ns/1ps

module tb_meta_buffer import axi_meta_pkg::*, noc_meta_pkg::*; ();

  localparam int TIMEOUT = 50;

  logic clk_i = 1'b0;
  logic arst_n_i;
  logic aw_valid_i, aw_ready_o, ar_valid_i, ar_ready_o;
  in_id_t aw_id_i, ar_id_i, b_id_o, r_id_o;
  addr_t aw_addr_i, ar_addr_i, aw_addr_o, ar_addr_o;
  atop_t aw_atop_i, aw_atop_o;
  src_id_t aw_src_i, ar_src_i, b_src_o, r_src_o;
  logic b_valid_o, b_ready_i, r_valid_o, r_ready_i, r_last_o;
  logic aw_valid_o, aw_ready_i, ar_valid_o, ar_ready_i;
  out_id_t aw_id_o, ar_id_o, b_id_i, r_id_i;
  logic b_valid_i, b_ready_o, r_valid_i, r_ready_o, r_last_i;

  int errors = 0;
  int timeouts = 0;
  int aw_rdy_mode = 1;
  logic hold_chk = 1'b0;
  // Records of the master and slave models
  logic [7:0] wq[$];
  logic [7:0] rq[$];
  logic [MAX_ATOP-1:0] at_wbusy = '0;
  logic [MAX_ATOP-1:0] at_rbusy = '0;
  in_id_t at_id [MAX_ATOP];
  src_id_t at_src [MAX_ATOP];
  in_id_t exp_b_id, exp_r_id;
  src_id_t exp_b_src, exp_r_src;

  meta_buffer_top dut0 (.*);

  always #5 clk_i = ~clk_i;

  function automatic void log_mismatch(string name, logic [ADDR_W-1:0] exp_v,
                                       logic [ADDR_W-1:0] act_v);
    errors++;
    $display("ERROR %s: expected %0d, actual %0d", name, exp_v, act_v);
  endfunction

  function automatic logic is_atop(atop_t a);
    return a[5:4] != ATOP_NONE;
  endfunction

  a_aw_id: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (aw_valid_o && !is_atop(aw_atop_i)) |-> aw_id_o == NO_ATOP_ID)
    else log_mismatch("aw_id", NO_ATOP_ID, $sampled(aw_id_o));
  a_aw_addr: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    aw_valid_o |-> aw_addr_o == aw_addr_i)
    else log_mismatch("aw_addr", aw_addr_i, $sampled(aw_addr_o));
  a_aw_atop: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    aw_valid_o |-> aw_atop_o == aw_atop_i)
    else log_mismatch("aw_atop", aw_atop_i, $sampled(aw_atop_o));
  a_ar_id: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ar_valid_o |-> ar_id_o == NO_ATOP_ID)
    else log_mismatch("ar_id", NO_ATOP_ID, $sampled(ar_id_o));
  a_ar_addr: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    ar_valid_o |-> ar_addr_o == ar_addr_i)
    else log_mismatch("ar_addr", ar_addr_i, $sampled(ar_addr_o));
  a_atop_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (aw_valid_o && is_atop(aw_atop_i)) |-> aw_id_o < MAX_ATOP)
    else log_mismatch("atop_id_range", MAX_ATOP - 1, $sampled(aw_id_o));
  a_atop_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (aw_valid_o && is_atop(aw_atop_i) && !aw_ready_i) |=>
    (aw_valid_o && aw_id_o == $past(aw_id_o)))
    else log_mismatch("atop_id_stable", $past(aw_id_o), $sampled(aw_id_o));
  a_b_resp: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (b_valid_o && b_ready_i) |-> (b_id_o == exp_b_id && b_src_o == exp_b_src))
    else log_mismatch("b_id_src", {exp_b_src, exp_b_id}, $sampled({b_src_o, b_id_o}));
  a_r_resp: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (r_valid_o && r_ready_i) |-> (r_id_o == exp_r_id && r_src_o == exp_r_src))
    else log_mismatch("r_id_src", {exp_r_src, exp_r_id}, $sampled({r_src_o, r_id_o}));
  a_r_last: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    r_valid_o |-> r_last_o == r_last_i)
    else log_mismatch("r_last", r_last_i, $sampled(r_last_o));
  a_resp_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    b_ready_o == b_ready_i && r_ready_o == r_ready_i)
    else log_mismatch("resp_ready", {b_ready_i, r_ready_i}, $sampled({b_ready_o, r_ready_o}));
  a_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    hold_chk |-> !aw_ready_o) else log_mismatch("aw_hold", 0, $sampled(aw_ready_o));
  a_no_resp: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    b_valid_o == b_valid_i && r_valid_o == r_valid_i)
    else log_mismatch("resp_valid", {b_valid_i, r_valid_i}, $sampled({b_valid_o, r_valid_o}));

  // Slave AW ready: 0 low, 1 high, 2 random
  always @(posedge clk_i) begin
    #1;
    aw_ready_i = (aw_rdy_mode == 2) ? ($urandom % 3 != 0) : (aw_rdy_mode == 1);
    ar_ready_i = ($urandom % 3 != 0);
  end

  // Handshakes complete on the next rising edge, so record them at the falling edge
  always @(negedge clk_i) begin
    if (aw_valid_i && aw_ready_o) begin
      if (is_atop(aw_atop_i)) begin
        a_atop_free: assert (!(at_wbusy[aw_id_o[0]] || at_rbusy[aw_id_o[0]]))
          else log_mismatch("atop_id_unique", 0, 1);
        at_wbusy[aw_id_o[0]] = 1'b1;
        at_rbusy[aw_id_o[0]] = aw_atop_i[ATOP_R_RESP_BIT];
        at_id[aw_id_o[0]] = aw_id_i;
        at_src[aw_id_o[0]] = aw_src_i;
      end else begin
        wq.push_back({aw_src_i, aw_id_i});
      end
    end
    if (ar_valid_i && ar_ready_o) rq.push_back({ar_src_i, ar_id_i});
    if (b_valid_i && b_ready_o) begin
      if (b_id_i < MAX_ATOP) at_wbusy[b_id_i[0]] = 1'b0;
      else void'(wq.pop_front());
    end
    if (r_valid_i && r_ready_o && r_last_i) begin
      if (r_id_i < MAX_ATOP) at_rbusy[r_id_i[0]] = 1'b0;
      else void'(rq.pop_front());
    end
  end

  task automatic start_aw(input in_id_t id, input atop_t atop, input src_id_t src);
    @(posedge clk_i);
    #1;
    aw_valid_i = 1'b1;
    aw_id_i = id;
    aw_atop_i = atop;
    aw_src_i = src;
    aw_addr_i = $urandom;
  endtask

  task automatic finish_aw();
    int n;
    n = 0;
    @(negedge clk_i);
    while (!aw_ready_o && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (n >= TIMEOUT) begin
      timeouts++;
      $display("Timeout: AW request was never accepted");
    end
    @(posedge clk_i);
    #1;
    aw_valid_i = 1'b0;
  endtask

  task automatic send_aw(input in_id_t id, input atop_t atop, input src_id_t src);
    start_aw(id, atop, src);
    finish_aw();
  endtask

  task automatic send_ar(input in_id_t id, input src_id_t src);
    int n;
    n = 0;
    @(posedge clk_i);
    #1;
    ar_valid_i = 1'b1;
    ar_id_i = id;
    ar_src_i = src;
    ar_addr_i = $urandom;
    @(negedge clk_i);
    while (!ar_ready_o && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (n >= TIMEOUT) begin
      timeouts++;
      $display("Timeout: AR request was never accepted");
    end
    @(posedge clk_i);
    #1;
    ar_valid_i = 1'b0;
  endtask

  task automatic send_b(input out_id_t id);
    int n;
    n = 0;
    repeat ($urandom % 4) @(posedge clk_i);
    @(posedge clk_i);
    #1;
    b_valid_i = 1'b1;
    b_id_i = id;
    exp_b_id = (id < MAX_ATOP) ? at_id[id[0]] : wq[0][3:0];
    exp_b_src = (id < MAX_ATOP) ? at_src[id[0]] : wq[0][7:4];
    @(negedge clk_i);
    while (!b_ready_o && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (n >= TIMEOUT) begin
      timeouts++;
      $display("Timeout: B response was never taken upstream");
    end
    @(posedge clk_i);
    #1;
    b_valid_i = 1'b0;
  endtask

  task automatic send_r(input out_id_t id, input int beats);
    repeat ($urandom % 4) @(posedge clk_i);
    exp_r_id = (id < MAX_ATOP) ? at_id[id[0]] : rq[0][3:0];
    exp_r_src = (id < MAX_ATOP) ? at_src[id[0]] : rq[0][7:4];
    for (int i = 0; i < beats; i++) begin
      @(posedge clk_i);
      #1;
      r_valid_i = 1'b1;
      r_id_i = id;
      r_last_i = (i == beats - 1);
    end
    @(posedge clk_i);
    #1;
    r_valid_i = 1'b0;
    r_last_i = 1'b0;
  endtask

  initial begin
    void'($urandom(83));
    {aw_valid_i, ar_valid_i, b_valid_i, r_valid_i, r_last_i} = '0;
    {aw_id_i, aw_addr_i, aw_atop_i, aw_src_i, ar_id_i, ar_addr_i, ar_src_i} = '0;
    {aw_ready_i, ar_ready_i, b_id_i, r_id_i} = '0;
    b_ready_i = 1'b1;
    r_ready_i = 1'b1;
    arst_n_i = 1'b0;
    repeat (3) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;

    // In-order non-atomic traffic under random slave ready
    aw_rdy_mode = 2;
    repeat (2) begin
      for (int i = 0; i < 3; i++) begin
        send_aw(in_id_t'($urandom), 6'h00, src_id_t'($urandom));
        send_ar(in_id_t'($urandom), src_id_t'($urandom));
      end
      for (int i = 0; i < 3; i++) begin
        send_b(NO_ATOP_ID);
        send_r(NO_ATOP_ID, 1 + i % 2);
      end
    end

    // Full write queue holds the fifth AW until one B returns
    aw_rdy_mode = 1;
    for (int i = 0; i < 4; i++) send_aw(in_id_t'(i + 4), 6'h00, src_id_t'(i));
    start_aw(4'hc, 6'h00, 4'h9);
    hold_chk = 1'b1;
    repeat (4) @(posedge clk_i);
    #1;
    hold_chk = 1'b0;
    send_b(NO_ATOP_ID);
    finish_aw();
    repeat (4) send_b(NO_ATOP_ID);

    // Atomics fill both slots, plain writes still pass
    send_aw(4'h1, 6'h20, 4'h5);
    send_aw(4'h2, 6'h10, 4'h6);
    send_aw(4'h3, 6'h00, 4'h7);
    send_b(NO_ATOP_ID);
    start_aw(4'h8, 6'h10, 4'ha);
    hold_chk = 1'b1;
    repeat (3) @(posedge clk_i);
    #1;
    hold_chk = 1'b0;
    aw_rdy_mode = 0;
    send_b(out_id_t'(1));
    // Slot 0 becomes free while the stalled AW still waits on slot 1
    send_b(out_id_t'(0));
    send_r(out_id_t'(0), 2);
    repeat (3) @(posedge clk_i);
    aw_rdy_mode = 1;
    finish_aw();
    send_b(out_id_t'(1));
    repeat (5) @(posedge clk_i);

    $display("Done: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: hw/meta_buffer_top.sv
// Top level of the meta buffer with plain AXI-style ports for integration and simulation
`timescale 1ns/1ps

module meta_buffer_top import axi_meta_pkg::*, noc_meta_pkg::*; (
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  logic    aw_valid_i,
  output logic    aw_ready_o,
  input  in_id_t  aw_id_i,
  input  addr_t   aw_addr_i,
  input  atop_t   aw_atop_i,
  input  src_id_t aw_src_i,
  input  logic    ar_valid_i,
  output logic    ar_ready_o,
  input  in_id_t  ar_id_i,
  input  addr_t   ar_addr_i,
  input  src_id_t ar_src_i,
  output logic    b_valid_o,
  input  logic    b_ready_i,
  output in_id_t  b_id_o,
  output src_id_t b_src_o,
  output logic    r_valid_o,
  input  logic    r_ready_i,
  output logic    r_last_o,
  output in_id_t  r_id_o,
  output src_id_t r_src_o,
  output logic    aw_valid_o,
  input  logic    aw_ready_i,
  output out_id_t aw_id_o,
  output addr_t   aw_addr_o,
  output atop_t   aw_atop_o,
  output logic    ar_valid_o,
  input  logic    ar_ready_i,
  output out_id_t ar_id_o,
  output addr_t   ar_addr_o,
  input  logic    b_valid_i,
  output logic    b_ready_o,
  input  out_id_t b_id_i,
  input  logic    r_valid_i,
  output logic    r_ready_o,
  input  logic    r_last_i,
  input  out_id_t r_id_i
);

  // Port names match one to one
  meta_buffer u_meta_buffer (.*);

endmodule

// File: hw/meta_buffer.sv
// Remaps request IDs toward the memory port and restores IDs and source nodes on responses
`timescale 1ns/1ps

module meta_buffer import axi_meta_pkg::*, noc_meta_pkg::*; (
  input  logic    clk_i,
  input  logic    arst_n_i,
  // Upstream requests
  input  logic    aw_valid_i,
  output logic    aw_ready_o,
  input  in_id_t  aw_id_i,
  input  addr_t   aw_addr_i,
  input  atop_t   aw_atop_i,
  input  src_id_t aw_src_i,
  input  logic    ar_valid_i,
  output logic    ar_ready_o,
  input  in_id_t  ar_id_i,
  input  addr_t   ar_addr_i,
  input  src_id_t ar_src_i,
  // Upstream responses
  output logic    b_valid_o,
  input  logic    b_ready_i,
  output in_id_t  b_id_o,
  output src_id_t b_src_o,
  output logic    r_valid_o,
  input  logic    r_ready_i,
  output logic    r_last_o,
  output in_id_t  r_id_o,
  output src_id_t r_src_o,
  // Downstream requests
  output logic    aw_valid_o,
  input  logic    aw_ready_i,
  output out_id_t aw_id_o,
  output addr_t   aw_addr_o,
  output atop_t   aw_atop_o,
  output logic    ar_valid_o,
  input  logic    ar_ready_i,
  output out_id_t ar_id_o,
  output addr_t   ar_addr_o,
  // Downstream responses
  input  logic    b_valid_i,
  output logic    b_ready_o,
  input  out_id_t b_id_i,
  input  logic    r_valid_i,
  output logic    r_ready_o,
  input  logic    r_last_i,
  input  out_id_t r_id_i
);

  logic                is_atop_aw;
  logic                atop_has_r;
  logic                atop_free;
  logic                aw_space;
  logic                aw_hs;
  logic                atop_alloc;
  logic                is_atop_b;
  logic                is_atop_r;
  logic                b_hs;
  logic                r_hs_last;
  logic [MAX_ATOP-1:0] wr_free;
  logic [MAX_ATOP-1:0] rd_free;
  slot_idx_t           wr_slot;
  slot_idx_t           rd_slot;
  wr_meta_t            wr_tab_meta;
  rd_meta_t            rd_tab_meta;
  wr_meta_t            b_meta;
  rd_meta_t            r_meta;

  meta_fifo_if #(.data_t(wr_meta_t)) wr_q ();
  meta_fifo_if #(.data_t(rd_meta_t)) rd_q ();

  // Write requests
  assign is_atop_aw = (aw_atop_i[5:4] != ATOP_NONE);
  assign atop_has_r = aw_atop_i[ATOP_R_RESP_BIT];

  // A read atomic needs the same slot number in both tables
  assign atop_free = wr_free[wr_slot] && rd_free[wr_slot] &&
                     (!atop_has_r || (rd_slot == wr_slot));
  assign aw_space  = is_atop_aw ? atop_free : !wr_q.full;

  assign aw_valid_o = aw_valid_i && aw_space;
  assign aw_ready_o = aw_ready_i && aw_space;
  assign aw_id_o    = is_atop_aw ? OUT_ID_W'(wr_slot) : NO_ATOP_ID;
  assign aw_addr_o  = aw_addr_i;
  assign aw_atop_o  = aw_atop_i;

  assign aw_hs      = aw_valid_o && aw_ready_i;
  assign atop_alloc = aw_valid_o && is_atop_aw;

  assign wr_q.push    = aw_hs && !is_atop_aw;
  assign wr_q.data_in = '{src: aw_src_i, id: aw_id_i};

  // Read requests
  assign ar_valid_o = ar_valid_i && !rd_q.full;
  assign ar_ready_o = ar_ready_i && !rd_q.full;
  assign ar_id_o    = NO_ATOP_ID;
  assign ar_addr_o  = ar_addr_i;

  assign rd_q.push    = ar_valid_o && ar_ready_i;
  assign rd_q.data_in = '{src: ar_src_i, id: ar_id_i, atop: 1'b0};

  // Responses with an ID below the slot count belong to atomics
  assign is_atop_b = (b_id_i < OUT_ID_W'(MAX_ATOP));
  assign is_atop_r = (r_id_i < OUT_ID_W'(MAX_ATOP));

  assign b_meta = is_atop_b ? wr_tab_meta : wr_q.data_out;
  assign r_meta = is_atop_r ? rd_tab_meta : rd_q.data_out;

  assign b_valid_o = b_valid_i;
  assign b_ready_o = b_ready_i;
  assign b_id_o    = b_meta.id;
  assign b_src_o   = b_meta.src;

  assign r_valid_o = r_valid_i;
  assign r_ready_o = r_ready_i;
  assign r_last_o  = r_last_i;
  assign r_id_o    = r_meta.id;
  assign r_src_o   = r_meta.src;

  assign b_hs      = b_valid_i && b_ready_i;
  assign r_hs_last = r_valid_i && r_ready_i && r_last_i;

  assign wr_q.pop = b_hs && !is_atop_b;
  assign rd_q.pop = r_hs_last && !is_atop_r;

  meta_fifo #(
    .data_t (wr_meta_t),
    .DEPTH  (MAX_TXNS)
  ) u_wr_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .q        (wr_q.queue)
  );

  meta_fifo #(
    .data_t (rd_meta_t),
    .DEPTH  (MAX_TXNS)
  ) u_rd_fifo (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .q        (rd_q.queue)
  );

  atop_slot_table #(
    .data_t (wr_meta_t)
  ) u_wr_slots (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .alloc_req_i  (atop_alloc),
    .alloc_done_i (aw_ready_i),
    .free_mask_o  (wr_free),
    .slot_o       (wr_slot),
    .load_i       (aw_hs && is_atop_aw),
    .data_i       ('{src: aw_src_i, id: aw_id_i}),
    .lookup_id_i  (b_id_i),
    .data_o       (wr_tab_meta),
    .release_i    (b_hs && is_atop_b)
  );

  atop_slot_table #(
    .data_t (rd_meta_t)
  ) u_rd_slots (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .alloc_req_i  (atop_alloc),
    .alloc_done_i (aw_ready_i),
    .free_mask_o  (rd_free),
    .slot_o       (rd_slot),
    .load_i       (aw_hs && is_atop_aw && atop_has_r),
    .data_i       ('{src: aw_src_i, id: aw_id_i, atop: 1'b1}),
    .lookup_id_i  (r_id_i),
    .data_o       (rd_tab_meta),
    .release_i    (r_hs_last && is_atop_r)
  );

endmodule

// File: hw/atop_slot_table.sv
// Per-slot metadata store for outstanding atomics, allocating the lowest free slot as their ID
`timescale 1ns/1ps

module atop_slot_table import axi_meta_pkg::*; #(
  parameter type data_t = logic
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                alloc_req_i,
  input  logic                alloc_done_i,
  output logic [MAX_ATOP-1:0] free_mask_o,
  output slot_idx_t           slot_o,
  input  logic                load_i,
  input  data_t               data_i,
  input  out_id_t             lookup_id_i,
  output data_t               data_o,
  input  logic                release_i
);

  logic [MAX_ATOP-1:0] valid_q;
  data_t               data_q [MAX_ATOP];
  slot_idx_t           lowest_free;
  slot_idx_t           slot_q;
  logic                pending_q;
  slot_idx_t           lookup_idx;
  logic                lookup_hit;

  assign free_mask_o = ~valid_q;

  // Scan downward so the last assignment wins with the lowest index
  always_comb begin
    lowest_free = '0;
    for (int i = MAX_ATOP - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        lowest_free = slot_idx_t'(i);
      end
    end
  end

  // A stalled request keeps the slot it was shown first
  assign slot_o = pending_q ? slot_q : lowest_free;

  assign lookup_hit = (lookup_id_i < OUT_ID_W'(MAX_ATOP));
  assign lookup_idx = slot_idx_t'(lookup_id_i);
  assign data_o     = data_q[lookup_idx];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q   <= '0;
      pending_q <= 1'b0;
      slot_q    <= '0;
    end else begin
      pending_q <= alloc_req_i && !alloc_done_i;
      if (alloc_req_i && !alloc_done_i) begin
        slot_q <= slot_o;
      end
      if (load_i) begin
        valid_q[slot_o] <= 1'b1;
      end
      // Load hits a free slot and release a busy one, so they never collide
      if (release_i && lookup_hit) begin
        valid_q[lookup_idx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      data_q[slot_o] <= data_i;
    end
  end

endmodule

// File: hw/meta_fifo.sv
// In-order metadata queue holding the buffered records of non-atomic requests
`timescale 1ns/1ps

module meta_fifo import axi_meta_pkg::*; #(
  parameter type data_t = logic,
  parameter int  DEPTH  = MAX_TXNS
) (
  input logic        clk_i,
  input logic        arst_n_i,
  meta_fifo_if.queue q
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  data_t            mem_q [DEPTH];
  logic             push_en;
  logic             pop_en;

  // A push into a full queue is ignored, a pop of an empty one as well
  assign push_en = q.push && !q.full;
  assign pop_en  = q.pop && (cnt_q != '0);

  assign q.full     = (cnt_q == CNT_W'(DEPTH));
  assign q.data_out = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_en) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_en) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_en, pop_en})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= q.data_in;
    end
  end

endmodule

// File: hw/meta_fifo_if.sv
// Push and pop bundle of one in-order metadata queue, connecting the meta buffer to its FIFO
`timescale 1ns/1ps

interface meta_fifo_if #(
  parameter type data_t = logic
);

  logic  push;
  logic  pop;
  logic  full;
  data_t data_in;
  data_t data_out;

  // Side that fills and drains the queue
  modport producer (output push, output pop, output data_in, input full, input data_out);

  // The storage itself
  modport queue (input push, input pop, input data_in, output full, output data_out);

endinterface

// File: hw/noc_meta_pkg.sv
// Network-side metadata records that the meta buffer holds until a response returns
package noc_meta_pkg;

  import axi_meta_pkg::*;

  // Node ID width of the network
  localparam int SRC_W = 4;

  typedef logic [SRC_W-1:0] src_id_t;

  // Held per outstanding write until its B response
  typedef struct packed {
    src_id_t src;
    in_id_t  id;
  } wr_meta_t;

  // Held per outstanding read until the last R beat
  typedef struct packed {
    src_id_t src;
    in_id_t  id;
    logic    atop;
  } rd_meta_t;

endpackage

// File: hw/axi_meta_pkg.sv
// AXI-side widths, ID types and atomic operation codes shared by the meta buffer RTL
package axi_meta_pkg;

  // Widths
  localparam int IN_ID_W  = 4;
  localparam int OUT_ID_W = 3;
  localparam int ADDR_W   = 32;

  // Outstanding transaction limits
  localparam int MAX_ATOP = 2;
  localparam int MAX_TXNS = 4;
  localparam int SLOT_W   = (MAX_ATOP > 1) ? $clog2(MAX_ATOP) : 1;

  typedef logic [IN_ID_W-1:0]  in_id_t;
  typedef logic [OUT_ID_W-1:0] out_id_t;
  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [SLOT_W-1:0]   slot_idx_t;

  // AXI5 atomic operation encoding
  typedef logic [5:0] atop_t;

  // Top two bits of atop_t for a plain, non-atomic write
  localparam logic [1:0] ATOP_NONE = 2'b00;

  // Set for atomics that also return read data
  localparam int ATOP_R_RESP_BIT = 5;

  // All non-atomic requests share the first ID above the atomic slots
  localparam out_id_t NO_ATOP_ID = OUT_ID_W'(MAX_ATOP);

endpackage
